/* source/rv_decode_pkg.sv */
// decode stage package with opcode and format encodings, decoded fields and default widths
package rv_decode_pkg;

    // default datapath sizes, overridden through module parameters at the top
    localparam int xlen_default      = 64;
    localparam int reg_count_default = 32;

    // base isa instruction word
    localparam int instr_width = 32;

    typedef logic [4:0]             reg_addr_t;
    typedef logic [instr_width-1:0] instr_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op        = 7'b0110011,
        op_32     = 7'b0111011,
        jalr      = 7'b1100111,
        load      = 7'b0000011,
        op_imm    = 7'b0010011,
        op_imm_32 = 7'b0011011,
        store     = 7'b0100011,
        branch    = 7'b1100011,
        lui       = 7'b0110111,
        auipc     = 7'b0010111,
        jal       = 7'b1101111,
        misc_mem  = 7'b0001111,
        system    = 7'b1110011
    } opcode_e;

    // instruction formats
    // fmt_none marks an opcode outside the set above
    typedef enum logic [2:0] {
        fmt_none = 3'd0,
        fmt_r    = 3'd1,
        fmt_i    = 3'd2,
        fmt_s    = 3'd3,
        fmt_b    = 3'd4,
        fmt_u    = 3'd5,
        fmt_j    = 3'd6
    } format_e;

    // one decoded instruction as handed to the next stage
    typedef struct packed {
        // raw major opcode, kept even when illegal
        logic [6:0] opcode;
        logic [2:0] funct3;
        // only meaningful for R format
        logic [6:0] funct7;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        format_e    format;
        logic       illegal;
        // sign-extended immediate for the format, zero for R
        logic [31:0] imm;
        // padding, always zero
        logic [3:0] spare;
    } decoded_instr_t;

endpackage

/* source/rv_instr_decoder.sv */
// instruction decoder, splits a 32-bit instruction into fields and a sign-extended immediate
module rv_instr_decoder (
    input  rv_decode_pkg::instr_t         instr,
    output rv_decode_pkg::decoded_instr_t decoded
);

    // major opcode seen as the package enum
    rv_decode_pkg::opcode_e op_code;
    rv_decode_pkg::format_e fmt;

    // one assembled immediate per format
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign op_code = rv_decode_pkg::opcode_e'(instr[6:0]);

    // opcode to format
    always_comb begin
        case (op_code)
            rv_decode_pkg::op,
            rv_decode_pkg::op_32: begin
                fmt = rv_decode_pkg::fmt_r;
            end
            rv_decode_pkg::jalr,
            rv_decode_pkg::load,
            rv_decode_pkg::op_imm,
            rv_decode_pkg::op_imm_32,
            rv_decode_pkg::misc_mem,
            rv_decode_pkg::system: begin
                fmt = rv_decode_pkg::fmt_i;
            end
            rv_decode_pkg::store: begin
                fmt = rv_decode_pkg::fmt_s;
            end
            rv_decode_pkg::branch: begin
                fmt = rv_decode_pkg::fmt_b;
            end
            rv_decode_pkg::lui,
            rv_decode_pkg::auipc: begin
                fmt = rv_decode_pkg::fmt_u;
            end
            rv_decode_pkg::jal: begin
                fmt = rv_decode_pkg::fmt_j;
            end
            // anything else is not a known major opcode
            default: begin
                fmt = rv_decode_pkg::fmt_none;
            end
        endcase
    end

    // I: 12-bit signed
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    // S: split across funct7 and rd slots
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // B: halfword offset, low bit always zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    // U: upper 20 bits, low 12 cleared
    assign imm_u = {instr[31:12], 12'b0};
    // J: 21-bit halfword offset
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // field selection per format
    // unused fields stay zero so later stages never see stale bits
    always_comb begin
        decoded         = '0;
        decoded.opcode  = instr[6:0];
        decoded.format  = fmt;
        decoded.illegal = (fmt == rv_decode_pkg::fmt_none);
        case (fmt)
            rv_decode_pkg::fmt_r: begin
                decoded.funct3 = instr[14:12];
                decoded.funct7 = instr[31:25];
                decoded.rs1    = instr[19:15];
                decoded.rs2    = instr[24:20];
                decoded.rd     = instr[11:7];
            end
            rv_decode_pkg::fmt_i: begin
                decoded.funct3 = instr[14:12];
                decoded.rs1    = instr[19:15];
                decoded.rd     = instr[11:7];
                decoded.imm    = imm_i;
            end
            rv_decode_pkg::fmt_s: begin
                decoded.funct3 = instr[14:12];
                decoded.rs1    = instr[19:15];
                decoded.rs2    = instr[24:20];
                decoded.imm    = imm_s;
            end
            rv_decode_pkg::fmt_b: begin
                decoded.funct3 = instr[14:12];
                decoded.rs1    = instr[19:15];
                decoded.rs2    = instr[24:20];
                decoded.imm    = imm_b;
            end
            rv_decode_pkg::fmt_u: begin
                decoded.rd  = instr[11:7];
                decoded.imm = imm_u;
            end
            rv_decode_pkg::fmt_j: begin
                decoded.rd  = instr[11:7];
                decoded.imm = imm_j;
            end
            // illegal, only opcode and flag survive
            default: begin
            end
        endcase
    end

endmodule

/* source/rv_register_file.sv */
// integer register file with two synchronous read ports, one write port and x0 tied to zero
module rv_register_file #(
    parameter int xlen      = 64,
    parameter int reg_count = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  rv_decode_pkg::reg_addr_t rs1_addr,
    input  rv_decode_pkg::reg_addr_t rs2_addr,
    input  logic                     wr_en,
    input  rv_decode_pkg::reg_addr_t wr_addr,
    input  logic [xlen-1:0]          wr_data,
    output logic [xlen-1:0]          rs1_data,
    output logic [xlen-1:0]          rs2_data
);

    // index width follows the register count, 4 bits for the embedded set
    localparam int addr_width = $clog2(reg_count);

    logic [xlen-1:0] regs [reg_count];

    logic [addr_width-1:0] rs1_index;
    logic [addr_width-1:0] rs2_index;
    logic [addr_width-1:0] wr_index;

    // addresses past the last register read zero and drop writes
    logic rs1_in_range;
    logic rs2_in_range;
    logic wr_in_range;

    assign rs1_index    = rs1_addr[addr_width-1:0];
    assign rs2_index    = rs2_addr[addr_width-1:0];
    assign wr_index     = wr_addr[addr_width-1:0];
    assign rs1_in_range = int'(rs1_addr) < reg_count;
    assign rs2_in_range = int'(rs2_addr) < reg_count;
    assign wr_in_range  = int'(wr_addr) < reg_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            // reads see the array before this edge's write, no bypass
            rs1_data <= rs1_in_range ? regs[rs1_index] : '0;
            rs2_data <= rs2_in_range ? regs[rs2_index] : '0;
            // x0 never written, so it keeps its reset zero
            if (wr_en && wr_in_range && (wr_addr != '0)) begin
                regs[wr_index] <= wr_data;
            end
        end
    end

endmodule

/* source/rv_decode_stage.sv */
// decode stage top, decodes the live instruction, reads its sources and registers it all
module rv_decode_stage #(
    parameter int xlen      = rv_decode_pkg::xlen_default,
    parameter int reg_count = rv_decode_pkg::reg_count_default
) (
    input  logic                          clk,
    input  logic                          reset,
    // fetch side, one instruction per cycle
    input  rv_decode_pkg::instr_t         instr,
    input  logic [xlen-1:0]               pc,
    // writeback port
    input  logic                          wr_en,
    input  rv_decode_pkg::reg_addr_t      wr_addr,
    input  logic [xlen-1:0]               wr_data,
    // to execute
    output rv_decode_pkg::decoded_instr_t decoded,
    output logic [xlen-1:0]               rs1_data,
    output logic [xlen-1:0]               rs2_data,
    output logic [xlen-1:0]               pc_out,
    output rv_decode_pkg::instr_t         instr_out
);

    // combinational decode of the instruction now at the input
    rv_decode_pkg::decoded_instr_t decoded_next;

    rv_instr_decoder decoder_i (
        .instr   (instr),
        .decoded (decoded_next)
    );

    // source reads launched from the live decode
    // the read data lands on the same edge as the pipeline registers below
    rv_register_file #(
        .xlen      (xlen),
        .reg_count (reg_count)
    ) register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (decoded_next.rs1),
        .rs2_addr (decoded_next.rs2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // pipeline register toward execute
    // cleared on reset, so illegal reads low out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            decoded   <= '0;
            pc_out    <= '0;
            instr_out <= '0;
        end else begin
            decoded   <= decoded_next;
            pc_out    <= pc;
            instr_out <= instr;
        end
    end

endmodule

/* include/decode_model.svh */
// reference model of the decode stage, predicts decoded fields and register reads
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// mirror of the architectural registers
logic [rv_decode_pkg::xlen_default-1:0] model_regs [rv_decode_pkg::reg_count_default];

// expected outputs after the last edge
rv_decode_pkg::decoded_instr_t          exp_decoded;
logic [rv_decode_pkg::xlen_default-1:0] exp_rs1_data;
logic [rv_decode_pkg::xlen_default-1:0] exp_rs2_data;
logic [rv_decode_pkg::xlen_default-1:0] exp_pc_out;
rv_decode_pkg::instr_t                  exp_instr_out;
int                                     model_errors = 0;

// rule by rule decode of one instruction
function automatic rv_decode_pkg::decoded_instr_t decode_expected(input rv_decode_pkg::instr_t ins);
    rv_decode_pkg::decoded_instr_t d;
    rv_decode_pkg::format_e        f;
    d = '0;
    d.opcode = ins[6:0];
    case (ins[6:0])
        rv_decode_pkg::op, rv_decode_pkg::op_32: f = rv_decode_pkg::fmt_r;
        rv_decode_pkg::jalr, rv_decode_pkg::load, rv_decode_pkg::op_imm,
        rv_decode_pkg::op_imm_32, rv_decode_pkg::misc_mem,
        rv_decode_pkg::system: f = rv_decode_pkg::fmt_i;
        rv_decode_pkg::store: f = rv_decode_pkg::fmt_s;
        rv_decode_pkg::branch: f = rv_decode_pkg::fmt_b;
        rv_decode_pkg::lui, rv_decode_pkg::auipc: f = rv_decode_pkg::fmt_u;
        rv_decode_pkg::jal: f = rv_decode_pkg::fmt_j;
        default: f = rv_decode_pkg::fmt_none;
    endcase
    d.format = f;
    if (f == rv_decode_pkg::fmt_none) begin
        d.illegal = 1'b1;
        return d;
    end
    // register and function fields
    d.rs1    = (f inside {rv_decode_pkg::fmt_u, rv_decode_pkg::fmt_j}) ? 5'd0 : ins[19:15];
    d.funct3 = (f inside {rv_decode_pkg::fmt_u, rv_decode_pkg::fmt_j}) ? 3'd0 : ins[14:12];
    d.rs2 = (f inside {rv_decode_pkg::fmt_r, rv_decode_pkg::fmt_s, rv_decode_pkg::fmt_b})
        ? ins[24:20] : 5'd0;
    d.rd     = (f inside {rv_decode_pkg::fmt_s, rv_decode_pkg::fmt_b}) ? 5'd0 : ins[11:7];
    d.funct7 = (f == rv_decode_pkg::fmt_r) ? ins[31:25] : 7'd0;
    // immediates via signed arithmetic
    case (f)
        rv_decode_pkg::fmt_i: d.imm = 32'($signed(ins[31:20]));
        rv_decode_pkg::fmt_s: d.imm = 32'($signed({ins[31:25], ins[11:7]}));
        rv_decode_pkg::fmt_b: d.imm = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        rv_decode_pkg::fmt_u: d.imm = 32'(ins[31:12]) << 12;
        rv_decode_pkg::fmt_j: d.imm = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        default: d.imm = '0;
    endcase
    return d;
endfunction

// back to the state right after reset
function automatic void clear_model();
    foreach (model_regs[i]) model_regs[i] = '0;
    exp_decoded   = '0;
    exp_rs1_data  = '0;
    exp_rs2_data  = '0;
    exp_pc_out    = '0;
    exp_instr_out = '0;
endfunction

// one rising edge, predict from old contents first, then write
function automatic void predict_edge(
    input rv_decode_pkg::instr_t                  ins,
    input logic [rv_decode_pkg::xlen_default-1:0] pc,
    input logic                                   we,
    input rv_decode_pkg::reg_addr_t               wa,
    input logic [rv_decode_pkg::xlen_default-1:0] wd
);
    exp_decoded   = decode_expected(ins);
    exp_rs1_data  = model_regs[exp_decoded.rs1];
    exp_rs2_data  = model_regs[exp_decoded.rs2];
    exp_pc_out    = pc;
    exp_instr_out = ins;
    if (we && wa != 5'd0) model_regs[wa] = wd;
endfunction

// compare one signal, log and count a mismatch
task automatic compare_value(input string name, input logic [63:0] got, exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        model_errors++;
    end
endtask

// check every DUT output against the prediction
task automatic check_outputs(
    input rv_decode_pkg::decoded_instr_t          dec,
    input logic [rv_decode_pkg::xlen_default-1:0] rs1_data,
    input logic [rv_decode_pkg::xlen_default-1:0] rs2_data,
    input logic [rv_decode_pkg::xlen_default-1:0] pc_out,
    input rv_decode_pkg::instr_t                  instr_out
);
    compare_value("opcode", 64'(dec.opcode), 64'(exp_decoded.opcode));
    compare_value("funct3", 64'(dec.funct3), 64'(exp_decoded.funct3));
    compare_value("funct7", 64'(dec.funct7), 64'(exp_decoded.funct7));
    compare_value("rs1", 64'(dec.rs1), 64'(exp_decoded.rs1));
    compare_value("rs2", 64'(dec.rs2), 64'(exp_decoded.rs2));
    compare_value("rd", 64'(dec.rd), 64'(exp_decoded.rd));
    compare_value("format", 64'(dec.format), 64'(exp_decoded.format));
    compare_value("illegal", 64'(dec.illegal), 64'(exp_decoded.illegal));
    compare_value("imm", 64'(dec.imm), 64'(exp_decoded.imm));
    compare_value("spare", 64'(dec.spare), 64'(exp_decoded.spare));
    compare_value("rs1_data", 64'(rs1_data), 64'(exp_rs1_data));
    compare_value("rs2_data", 64'(rs2_data), 64'(exp_rs2_data));
    compare_value("pc_out", 64'(pc_out), 64'(exp_pc_out));
    compare_value("instr_out", 64'(instr_out), 64'(exp_instr_out));
endtask

`endif

/* sim/tb_decode_stage.sv */
// testbench for the decode stage, random instructions and writebacks checked against a model
module tb_decode_stage;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 5;
    localparam int num_cycles   = 2000;
    // extra cycles of slack before the watchdog fires
    localparam int slack_cycles = 50;
    localparam int seed         = 83295;
    localparam int xlen         = rv_decode_pkg::xlen_default;

    logic                          clk;
    logic                          reset;
    rv_decode_pkg::instr_t         instr;
    logic [xlen-1:0]               pc;
    logic                          wr_en;
    rv_decode_pkg::reg_addr_t      wr_addr;
    logic [xlen-1:0]               wr_data;
    rv_decode_pkg::decoded_instr_t decoded;
    logic [xlen-1:0]               rs1_data;
    logic [xlen-1:0]               rs2_data;
    logic [xlen-1:0]               pc_out;
    rv_decode_pkg::instr_t         instr_out;

    // expected outputs, register mirror and error counter
    `include "decode_model.svh"

    // the thirteen recognised major opcodes
    rv_decode_pkg::opcode_e legal_ops [13] = '{
        rv_decode_pkg::op,        rv_decode_pkg::op_32,     rv_decode_pkg::jalr,
        rv_decode_pkg::load,      rv_decode_pkg::op_imm,    rv_decode_pkg::op_imm_32,
        rv_decode_pkg::store,     rv_decode_pkg::branch,    rv_decode_pkg::lui,
        rv_decode_pkg::auipc,     rv_decode_pkg::jal,       rv_decode_pkg::misc_mem,
        rv_decode_pkg::system
    };

    // stimulus statistics for the closing line
    int illegal_count = 0;
    int x0_write_count = 0;
    int hazard_count = 0;

    rv_decode_stage rv_decode_stage_i (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .pc        (pc),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .decoded   (decoded),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .pc_out    (pc_out),
        .instr_out (instr_out)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // one random decode slot plus writeback, applied on the falling edge
    task automatic drive_random();
        logic [31:0] bits;
        logic [6:0]  op;
        logic [3:0]  idx;
        bits = $urandom();
        // mostly legal opcodes, the rest anything at all
        if ($urandom_range(99) < 85) begin
            idx = 4'($urandom_range(12));
            op  = legal_ops[idx];
        end else begin
            op = 7'($urandom());
        end
        instr   = {bits[31:7], op};
        pc      = {$urandom(), $urandom()};
        wr_en   = 1'($urandom());
        wr_addr = 5'($urandom());
        wr_data = {$urandom(), $urandom()};
    endtask

    // tally what this slot exercises
    task automatic count_cases();
        if (exp_decoded.illegal) begin
            illegal_count++;
        end
        if (wr_en && wr_addr == 5'd0) begin
            x0_write_count++;
        end
        // write and read of the same register on one edge
        if (wr_en && wr_addr != 5'd0
            && (wr_addr == exp_decoded.rs1 || wr_addr == exp_decoded.rs2)) begin
            hazard_count++;
        end
    endtask

    // each stimulus class has to show up at least once
    task automatic check_case_counts();
        if (illegal_count == 0) begin
            $display("no illegal opcode was driven during the run");
            model_errors++;
        end
        if (x0_write_count == 0) begin
            $display("no write to x0 was driven during the run");
            model_errors++;
        end
        if (hazard_count == 0) begin
            $display("no write and read of one register on the same edge occurred");
            model_errors++;
        end
    endtask

    // watchdog, sized from reset plus test length plus slack
    initial begin
        #((reset_cycles + num_cycles + slack_cycles) * clk_period);
        $display("watchdog: run timed out before all %0d cycles completed", num_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(seed));
        // every input defined from time zero
        reset   = 1'b1;
        instr   = '0;
        pc      = '0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        clear_model();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // outputs straight out of reset
        check_outputs(decoded, rs1_data, rs2_data, pc_out, instr_out);

        for (int i = 0; i < num_cycles; i++) begin
            drive_random();
            // prediction for the coming rising edge, then its write
            predict_edge(instr, pc, wr_en, wr_addr, wr_data);
            count_cases();
            @(negedge clk);
            check_outputs(decoded, rs1_data, rs2_data, pc_out, instr_out);
        end

        check_case_counts();
        $display("done: %0d cycles, %0d illegal, %0d x0 writes, %0d same-edge hazards, %0d errors",
                 num_cycles, illegal_count, x0_write_count, hazard_count, model_errors);
        if (model_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
source/rv_decode_pkg.sv
source/rv_instr_decoder.sv
source/rv_register_file.sv
source/rv_decode_stage.sv
sim/tb_decode_stage.sv

/* Makefile */
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
BUILD_DIR ?= obj_dir
FILE_LIST ?= sources.f
PASS_TEXT ?= STATUS: PASS

BINARY := $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILE_LIST) $(wildcard source/*.sv sim/*.sv include/*.svh)
	$(VERILATOR) --binary --timing \
		--top-module $(TOP) \
		--Mdir $(BUILD_DIR) \
		-o $(TOP) \
		-f $(FILE_LIST)

# output goes to the terminal, exit status comes from the search
run: compile
	@out="$$(./$(BINARY))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit $$status; fi; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
